//--- rtl/commit_ctrl.sv
// Commit control
// Tracks start of packet, gates the forwarding handshake against the commit
// buffer and holds the completion of a packet until its last beat

`timescale 1ns/1ps

module commit_ctrl (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              sink_tvalid,
   input  logic                              sink_tlast,
   input  logic [tx_commit_pkg::USER_W-1:0]  sink_tuser,
   input  logic                              src_tready,
   input  logic                              needs_cpl,
   input  tx_commit_pkg::cpl_hdr_t           cpl_hdr,
   input  logic                              in_ready,
   output logic                              sink_tready,
   output logic                              src_tvalid,
   output logic                              sop,
   output logic                              in_valid,
   output tx_commit_pkg::cpl_hdr_t           in_hdr,
   output logic [tx_commit_pkg::USER_W-1:0]  in_user
);

   logic                             skid_ok;
   logic                             accept;
   logic                             pend_valid;
   tx_commit_pkg::cpl_hdr_t          pend_hdr;
   logic [tx_commit_pkg::USER_W-1:0] pend_user;

   // ------------------------------------------------------------------------
   // Handshake gating
   // ------------------------------------------------------------------------

   // Commits are only pushed on the last beat, so only last beats wait
   // for room in the commit buffer
   assign skid_ok = in_ready || !sink_tlast;

   assign sink_tready = src_tready && skid_ok;
   // The forwarded beat must not leave unless the sink beat is taken too
   assign src_tvalid  = sink_tvalid && skid_ok;
   assign accept      = sink_tvalid && sink_tready;

   // ------------------------------------------------------------------------
   // Start of packet and pending commit
   // ------------------------------------------------------------------------

   // The beat after a last beat opens a new packet
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         sop <= 1'b1;
      else if (accept)
         sop <= sink_tlast;
   end

   // A commit is pending between the header beat and the last beat of a
   // multi-beat packet. Single-beat packets never use the register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pend_valid <= 1'b0;
      else if (accept)
      begin
         if (sink_tlast)
            pend_valid <= 1'b0;
         else if (sop)
            pend_valid <= needs_cpl;
      end
   end

   // Header and tuser are captured from the first beat only
   always_ff @(posedge clk)
   begin
      if (accept && sop)
      begin
         pend_hdr  <= cpl_hdr;
         pend_user <= sink_tuser;
      end
   end

   // Push the commit as the last beat is accepted. A single-beat packet
   // takes the live decode, longer ones take the captured copy
   assign in_valid = accept && sink_tlast && (sop ? needs_cpl : pend_valid);
   assign in_hdr   = sop ? cpl_hdr : pend_hdr;
   assign in_user  = sop ? sink_tuser : pend_user;

endmodule

//--- rtl/commit_skid.sv
// Commit skid buffer
// Two-entry registered buffer on the commit stream, an output register
// plus an overflow register, so in_ready comes straight from a flop

`timescale 1ns/1ps

module commit_skid #(
   parameter int DATA_W = 256
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              in_valid,
   input  tx_commit_pkg::cpl_hdr_t           in_hdr,
   input  logic [tx_commit_pkg::USER_W-1:0]  in_user,
   input  logic                              commit_tready,
   output logic                              in_ready,
   output logic                              commit_tvalid,
   output logic [DATA_W-1:0]                 commit_tdata,
   output logic [DATA_W/8-1:0]               commit_tkeep,
   output logic                              commit_tlast,
   output logic [tx_commit_pkg::USER_W-1:0]  commit_tuser
);

   localparam int CPL_BYTES = tx_commit_pkg::CPL_W / 8;

   logic                             push;
   logic                             out_ready;
   logic                             out_valid;
   logic                             ovf_valid;
   logic                             ovf_valid_nxt;
   tx_commit_pkg::cpl_hdr_t          out_hdr;
   tx_commit_pkg::cpl_hdr_t          ovf_hdr;
   logic [tx_commit_pkg::USER_W-1:0] out_user;
   logic [tx_commit_pkg::USER_W-1:0] ovf_user;

   assign push      = in_valid && in_ready;
   // Output register can take a new entry when empty or draining
   assign out_ready = !out_valid || commit_tready;

   // Overflow fills only when the output is stalled and a commit arrives.
   // It drains into the output register as soon as that moves
   always_comb
   begin
      if (out_ready)
         ovf_valid_nxt = 1'b0;
      else
         ovf_valid_nxt = ovf_valid || push;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         out_valid <= 1'b0;
         ovf_valid <= 1'b0;
         in_ready  <= 1'b0;
      end
      else
      begin
         if (out_ready)
            out_valid <= ovf_valid || push;
         ovf_valid <= ovf_valid_nxt;
         in_ready  <= !ovf_valid_nxt;
      end
   end

   // Payload registers, older overflow entry goes out first
   always_ff @(posedge clk)
   begin
      if (out_ready)
      begin
         if (ovf_valid)
         begin
            out_hdr  <= ovf_hdr;
            out_user <= ovf_user;
         end
         else if (push)
         begin
            out_hdr  <= in_hdr;
            out_user <= in_user;
         end
      end
      else if (push)
      begin
         ovf_hdr  <= in_hdr;
         ovf_user <= in_user;
      end
   end

   // Header in the low bytes, every commit is a single beat
   assign commit_tvalid = out_valid;
   assign commit_tdata  = {{(DATA_W - tx_commit_pkg::CPL_W){1'b0}}, out_hdr};
   assign commit_tkeep  = {{(DATA_W/8 - CPL_BYTES){1'b0}}, {CPL_BYTES{1'b1}}};
   assign commit_tlast  = 1'b1;
   assign commit_tuser  = out_user;

endmodule

//--- rtl/cpl_hdr_build.sv
// Completion header builder
// Forms the completion for DM writes, PU writes and DM interrupts and
// clears the PU metadata bytes in the forwarded header

`timescale 1ns/1ps

module cpl_hdr_build #(
   parameter int DATA_W = 256
) (
   input  logic [DATA_W-1:0]        sink_tdata,
   input  logic                     is_wr,
   input  logic                     is_intr,
   input  logic                     is_dm,
   input  logic                     sop,
   input  logic                     needs_cpl,
   output logic [DATA_W-1:0]        fwd_tdata,
   output tx_commit_pkg::cpl_hdr_t  cpl_hdr
);

   tx_commit_pkg::req_hdr_u hdr;
   tx_commit_pkg::cpl_hdr_t dm_cpl;
   tx_commit_pkg::cpl_hdr_t pu_cpl;
   tx_commit_pkg::cpl_hdr_t intr_cpl;

   assign hdr = sink_tdata[tx_commit_pkg::HDR_W-1:0];

   // ------------------------------------------------------------------------
   // Completion variants
   // ------------------------------------------------------------------------
   always_comb
   begin
      // DM write, most fields loop back unchanged
      dm_cpl           = '0;
      dm_cpl.fmt_type  = tx_commit_pkg::FMT_CPL;
      dm_cpl.metadata  = hdr.dm.metadata;
      dm_cpl.pf_num    = hdr.dm.pf_num;
      dm_cpl.vf_num    = hdr.dm.vf_num;
      dm_cpl.vf_active = hdr.dm.vf_active;
      dm_cpl.length    = hdr.dm.length;
      dm_cpl.tag       = hdr.dm.tag;
      dm_cpl.fc        = 1'b1;

      // PU write also returns the requester id
      pu_cpl           = '0;
      pu_cpl.fmt_type  = tx_commit_pkg::FMT_CPL;
      pu_cpl.metadata  = hdr.pu.metadata;
      pu_cpl.req_id    = hdr.pu.req_id;
      pu_cpl.pf_num    = hdr.pu.pf_num;
      pu_cpl.vf_num    = hdr.pu.vf_num;
      pu_cpl.vf_active = hdr.pu.vf_active;
      pu_cpl.length    = 24'(hdr.pu.length);
      pu_cpl.tag       = hdr.pu.tag;
      // PU length counts dwords, byte count is four times that
      pu_cpl.byte_count = {hdr.pu.length, 2'b00};

      // Interrupt returns the vector number in the metadata
      intr_cpl           = '0;
      intr_cpl.fmt_type  = tx_commit_pkg::FMT_CPL;
      intr_cpl.metadata  = 64'(hdr.intr.vector_num);
      intr_cpl.pf_num    = hdr.intr.pf_num;
      intr_cpl.vf_num    = hdr.intr.vf_num;
      intr_cpl.vf_active = hdr.intr.vf_active;
      intr_cpl.fc        = 1'b1;
      // tc bit 0 tells the accelerator this was an interrupt
      intr_cpl.tc        = 3'b001;
   end

   // Write takes priority; is_intr already implies DM mode
   always_comb
   begin
      if (is_wr)
         cpl_hdr = is_dm ? dm_cpl : pu_cpl;
      else if (is_intr)
         cpl_hdr = intr_cpl;
      else
         cpl_hdr = '0;
   end

   // ------------------------------------------------------------------------
   // Forwarded data
   // ------------------------------------------------------------------------

   // The host side treats PU bytes 8-15 as reserved, so metadata that only
   // feeds the local completion is cleared before the header leaves
   always_comb
   begin
      fwd_tdata = sink_tdata;
      if (sop && needs_cpl && !is_dm)
         fwd_tdata[tx_commit_pkg::META_LSB +: tx_commit_pkg::META_W] = '0;
   end

endmodule

//--- rtl/tx_commit_pkg.sv
// TX commit generator shared definitions
// Header widths, format-type codes, the request header views and the
// locally generated completion header

package tx_commit_pkg;

   // ------------------------------------------------------------------------
   // Widths and side band bit positions
   // ------------------------------------------------------------------------

   // Request headers sit in the low HDR_W bits of the first data beat
   localparam int HDR_W = 128;

   // Generated completions carry every copied field at full width.
   // This does not fit in 128 bits, so the commit header is 20 bytes wide
   // and the stream data width must be at least CPL_W
   localparam int CPL_W = 160;

   localparam int USER_W      = 8;
   localparam int USER_DM_BIT = 0;

   // Metadata occupies header bytes 8-15 in both request encodings
   localparam int META_LSB = 64;
   localparam int META_W   = 64;

   // ------------------------------------------------------------------------
   // Format-type codes
   // ------------------------------------------------------------------------
   localparam logic [7:0] FMT_MRD32 = 8'h00;
   localparam logic [7:0] FMT_MRD64 = 8'h20;
   localparam logic [7:0] FMT_MWR32 = 8'h40;
   localparam logic [7:0] FMT_MWR64 = 8'h60;
   // Interrupt requests exist only in DM encoding
   localparam logic [7:0] FMT_INTR  = 8'h30;
   // Completion without data
   localparam logic [7:0] FMT_CPL   = 8'h0a;

   // DM request header, 24 bit length
   typedef struct packed {
      logic [63:0] metadata;
      logic [7:0]  fmt_type;
      logic [23:0] length;
      logic [9:0]  tag;
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
      logic [6:0]  pad;
   } dm_req_hdr_t;

   // PU request header, metadata lives in the bytes PCIe marks reserved
   typedef struct packed {
      logic [63:0] metadata;
      logic [7:0]  fmt_type;
      logic [9:0]  length;
      logic [9:0]  tag;
      logic [15:0] req_id;
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
      logic [4:0]  pad;
   } pu_req_hdr_t;

   // DM interrupt header
   typedef struct packed {
      logic [63:0] rsvd;
      logic [7:0]  fmt_type;
      logic [15:0] vector_num;
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
      logic [24:0] pad;
   } intr_hdr_t;

   // One header word, decoded as DM, PU or interrupt by the tuser mode bit
   typedef union packed {
      dm_req_hdr_t dm;
      pu_req_hdr_t pu;
      intr_hdr_t   intr;
   } req_hdr_u;

   // Completion without data, built locally for each committed request
   typedef struct packed {
      logic [63:0] metadata;
      logic [7:0]  fmt_type;
      logic [2:0]  tc;
      logic        fc;
      logic [23:0] length;
      logic [11:0] byte_count;
      logic [9:0]  tag;
      logic [15:0] req_id;
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
      logic [6:0]  pad;
   } cpl_hdr_t;

endpackage

//--- rtl/tx_commit_top.sv
// TX commit generator top level
// Forwards the request stream to the host side and emits a completion
// on the commit stream for every write and DM interrupt request

`timescale 1ns/1ps

module tx_commit_top #(
   parameter int DATA_W        = 256,
   // tuser bit that suppresses a commit, 0 turns suppression off
   parameter int NO_COMMIT_BIT = 1
) (
   input  logic                              clk,
   input  logic                              rst_n,

   // Requests from the accelerator
   input  logic                              sink_tvalid,
   output logic                              sink_tready,
   input  logic [DATA_W-1:0]                 sink_tdata,
   input  logic [DATA_W/8-1:0]               sink_tkeep,
   input  logic                              sink_tlast,
   input  logic [tx_commit_pkg::USER_W-1:0]  sink_tuser,

   // Requests toward the host interface
   output logic                              src_tvalid,
   input  logic                              src_tready,
   output logic [DATA_W-1:0]                 src_tdata,
   output logic [DATA_W/8-1:0]               src_tkeep,
   output logic                              src_tlast,
   output logic [tx_commit_pkg::USER_W-1:0]  src_tuser,

   // Locally generated completions
   output logic                              commit_tvalid,
   input  logic                              commit_tready,
   output logic [DATA_W-1:0]                 commit_tdata,
   output logic [DATA_W/8-1:0]               commit_tkeep,
   output logic                              commit_tlast,
   output logic [tx_commit_pkg::USER_W-1:0]  commit_tuser
);

   logic                             is_wr;
   logic                             is_intr;
   logic                             is_dm;
   logic                             needs_cpl;
   logic                             sop;
   logic                             in_valid;
   logic                             in_ready;
   tx_commit_pkg::cpl_hdr_t          cpl_hdr;
   tx_commit_pkg::cpl_hdr_t          in_hdr;
   logic [tx_commit_pkg::USER_W-1:0] in_user;
   logic [DATA_W-1:0]                fwd_tdata;

   // Side band fields pass straight through, only the data may be scrubbed
   assign src_tdata = fwd_tdata;
   assign src_tkeep = sink_tkeep;
   assign src_tlast = sink_tlast;
   assign src_tuser = sink_tuser;

   // Classify the first-beat header
   tx_hdr_decode #(
      .NO_COMMIT_BIT(NO_COMMIT_BIT)
   ) u_decode (
      .sink_tdata (sink_tdata[tx_commit_pkg::HDR_W-1:0]),
      .sink_tuser (sink_tuser),
      .is_wr      (is_wr),
      .is_intr    (is_intr),
      .is_dm      (is_dm),
      .needs_cpl  (needs_cpl)
   );

   // Completion header and metadata scrub
   cpl_hdr_build #(
      .DATA_W(DATA_W)
   ) u_build (
      .sink_tdata (sink_tdata),
      .is_wr      (is_wr),
      .is_intr    (is_intr),
      .is_dm      (is_dm),
      .sop        (sop),
      .needs_cpl  (needs_cpl),
      .fwd_tdata  (fwd_tdata),
      .cpl_hdr    (cpl_hdr)
   );

   // Handshake gating and the pending commit
   commit_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .sink_tvalid (sink_tvalid),
      .sink_tlast  (sink_tlast),
      .sink_tuser  (sink_tuser),
      .src_tready  (src_tready),
      .needs_cpl   (needs_cpl),
      .cpl_hdr     (cpl_hdr),
      .in_ready    (in_ready),
      .sink_tready (sink_tready),
      .src_tvalid  (src_tvalid),
      .sop         (sop),
      .in_valid    (in_valid),
      .in_hdr      (in_hdr),
      .in_user     (in_user)
   );

   // Registered output stage of the commit stream
   commit_skid #(
      .DATA_W(DATA_W)
   ) u_skid (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .in_hdr        (in_hdr),
      .in_user       (in_user),
      .commit_tready (commit_tready),
      .in_ready      (in_ready),
      .commit_tvalid (commit_tvalid),
      .commit_tdata  (commit_tdata),
      .commit_tkeep  (commit_tkeep),
      .commit_tlast  (commit_tlast),
      .commit_tuser  (commit_tuser)
   );

endmodule

//--- rtl/tx_hdr_decode.sv
// Request header decode
// Classifies the first-beat header as write or interrupt, picks the
// encoding from tuser and decides whether a completion is needed

`timescale 1ns/1ps

module tx_hdr_decode #(
   // tuser bit that suppresses a commit, 0 turns suppression off
   parameter int NO_COMMIT_BIT = 1
) (
   input  logic [tx_commit_pkg::HDR_W-1:0]   sink_tdata,
   input  logic [tx_commit_pkg::USER_W-1:0]  sink_tuser,
   output logic                              is_wr,
   output logic                              is_intr,
   output logic                              is_dm,
   output logic                              needs_cpl
);

   tx_commit_pkg::req_hdr_u hdr;
   logic                    suppress;

   // Same header word, read through whichever view the mode selects
   assign hdr = sink_tdata;

   // DM and PU share the fmt_type position, so either view works for writes
   assign is_dm = sink_tuser[tx_commit_pkg::USER_DM_BIT];

   assign is_wr = (hdr.dm.fmt_type == tx_commit_pkg::FMT_MWR32) ||
                  (hdr.dm.fmt_type == tx_commit_pkg::FMT_MWR64);

   // A PU header carrying the interrupt code is not an interrupt
   assign is_intr = is_dm && (hdr.intr.fmt_type == tx_commit_pkg::FMT_INTR);

   // Bit index 0 is the DM flag, so it doubles as the off setting
   assign suppress = (NO_COMMIT_BIT != 0) ? sink_tuser[NO_COMMIT_BIT] : 1'b0;

   // Only meaningful on a start-of-packet beat, commit_ctrl samples it there
   assign needs_cpl = (is_wr || is_intr) && !suppress;

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the TX commit testbench with Verilator and runs it.
# Exits non-zero unless the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log
TOP=tx_commit_tb

rm -f "$LOG"

verilator --binary --timing \
   --top-module "$TOP" \
   -Mdir "$BUILD_DIR" \
   -f tx_commit_top.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
fi

if grep -qx ">>> PASS" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi

echo "Simulation failed, see $LOG"
exit 1

//--- tests/tx_commit_tb.sv
// Testbench for the TX commit generator
// Drives random DM/PU requests under back-pressure and checks the
// forwarded stream and the commit stream against a reference model

`timescale 1ns/1ps

module tx_commit_tb;

   localparam int DATA_W         = 256;
   localparam int KEEP_W         = DATA_W / 8;
   localparam int NO_COMMIT      = 1;
   localparam int NUM_PKTS       = 400;
   localparam int MAX_BEATS      = 4;
   localparam int TIMEOUT_CYCLES = NUM_PKTS * MAX_BEATS * 10;

   // Request kinds picked by the stimulus
   localparam int K_DM_WR   = 0;
   localparam int K_PU_WR   = 1;
   localparam int K_DM_RD   = 2;
   localparam int K_PU_RD   = 3;
   localparam int K_DM_INTR = 4;
   localparam int K_PU_INTR = 5;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              sink_tvalid;
   logic              sink_tready;
   logic [DATA_W-1:0] sink_tdata;
   logic [KEEP_W-1:0] sink_tkeep;
   logic              sink_tlast;
   logic [7:0]        sink_tuser;
   logic              src_tvalid;
   logic              src_tready;
   logic [DATA_W-1:0] src_tdata;
   logic [KEEP_W-1:0] src_tkeep;
   logic              src_tlast;
   logic [7:0]        src_tuser;
   logic              commit_tvalid;
   logic              commit_tready;
   logic [DATA_W-1:0] commit_tdata;
   logic [KEEP_W-1:0] commit_tkeep;
   logic              commit_tlast;
   logic [7:0]        commit_tuser;

   integer seed = 32'h57da_97a8;
   int     cycle_count = 0;
   int     commit_count = 0;
   logic   commit_due = 1'b0;

   // Expected forwarded beats with one entry per driven beat
   logic [DATA_W-1:0] fwd_data_q[$];
   logic [KEEP_W-1:0] fwd_keep_q[$];
   logic              fwd_last_q[$];
   logic [7:0]        fwd_user_q[$];
   // Per packet predictions that wait for the packet's last beat
   logic                    pend_has_q[$];
   tx_commit_pkg::cpl_hdr_t pend_cpl_q[$];
   logic [7:0]              pend_user_q[$];
   // Commits that are owed once the last beat has been accepted
   tx_commit_pkg::cpl_hdr_t exp_cpl_q[$];
   logic [7:0]              exp_cuser_q[$];

   tx_commit_top #(
      .DATA_W        (DATA_W),
      .NO_COMMIT_BIT (NO_COMMIT)
   ) uut (
      .clk           (clk),
      .rst_n         (rst_n),
      .sink_tvalid   (sink_tvalid),
      .sink_tready   (sink_tready),
      .sink_tdata    (sink_tdata),
      .sink_tkeep    (sink_tkeep),
      .sink_tlast    (sink_tlast),
      .sink_tuser    (sink_tuser),
      .src_tvalid    (src_tvalid),
      .src_tready    (src_tready),
      .src_tdata     (src_tdata),
      .src_tkeep     (src_tkeep),
      .src_tlast     (src_tlast),
      .src_tuser     (src_tuser),
      .commit_tvalid (commit_tvalid),
      .commit_tready (commit_tready),
      .commit_tdata  (commit_tdata),
      .commit_tkeep  (commit_tkeep),
      .commit_tlast  (commit_tlast),
      .commit_tuser  (commit_tuser)
   );

   always #4 clk = ~clk;

   task automatic stop_with_failure();
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                           input string what);
      if (got !== exp)
      begin
         $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   function automatic logic [DATA_W-1:0] rand_word();
      logic [DATA_W-1:0] w;
      for (int i = 0; i < DATA_W / 32; i++)
         w[i*32 +: 32] = $random(seed);
      return w;
   endfunction

   // ------------------------------------------------------------------------
   // Reference model of the completion for each request kind
   // ------------------------------------------------------------------------
   function automatic tx_commit_pkg::cpl_hdr_t predict_completion(input logic [127:0] word,
                                                                  input int kind);
      tx_commit_pkg::dm_req_hdr_t d;
      tx_commit_pkg::pu_req_hdr_t p;
      tx_commit_pkg::intr_hdr_t   i;
      tx_commit_pkg::cpl_hdr_t    c;
      d = word;
      p = word;
      i = word;
      c = '0;
      c.fmt_type = tx_commit_pkg::FMT_CPL;
      if (kind == K_DM_WR)
      begin
         c.metadata  = d.metadata;
         c.pf_num    = d.pf_num;
         c.vf_num    = d.vf_num;
         c.vf_active = d.vf_active;
         c.length    = d.length;
         c.tag       = d.tag;
         c.fc        = 1'b1;
      end
      else if (kind == K_PU_WR)
      begin
         // Metadata comes from the request before the scrub
         c.metadata   = p.metadata;
         c.req_id     = p.req_id;
         c.pf_num     = p.pf_num;
         c.vf_num     = p.vf_num;
         c.vf_active  = p.vf_active;
         c.length     = 24'(p.length);
         c.tag        = p.tag;
         c.byte_count = 12'(p.length) * 12'd4;
      end
      else if (kind == K_DM_INTR)
      begin
         c.metadata  = {48'b0, i.vector_num};
         c.pf_num    = i.pf_num;
         c.vf_num    = i.vf_num;
         c.vf_active = i.vf_active;
         c.fc        = 1'b1;
         c.tc        = 3'b001;
      end
      return c;
   endfunction

   // Advance one clock. The sink handshake is sampled mid-cycle where it is
   // stable, and both ready inputs are redrawn just after the edge
   task automatic tick(output logic accepted);
      @(negedge clk);
      accepted = sink_tvalid && sink_tready;
      @(posedge clk);
      #1;
      src_tready    = ({$random(seed)} % 10) >= 3;
      commit_tready = ({$random(seed)} % 10) >= 3;
   endtask

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   // ------------------------------------------------------------------------
   // Monitor on both output streams
   // ------------------------------------------------------------------------

   // Sampling happens mid-cycle
   always @(negedge clk)
   begin : monitor
      logic                    sink_xfer;
      logic                    src_xfer;
      logic                    has;
      tx_commit_pkg::cpl_hdr_t c;
      logic [7:0]              u;
      logic [DATA_W-1:0]       exp_data;
      logic [KEEP_W-1:0]       exp_keep;
      if (!rst_n)
      begin
         check_eq(256'(src_tvalid), 256'(0), "src_tvalid during reset");
         check_eq(256'(commit_tvalid), 256'(0), "commit_tvalid during reset");
         check_eq(256'(sink_tready), 256'(0), "sink_tready during reset");
      end
      else
      begin
         // A commit pushed into a free output stage appears one cycle later
         if (commit_due)
            check_eq(256'(commit_tvalid), 256'(1), "commit_tvalid one cycle after last beat");
         commit_due = 1'b0;

         // Commits are checked before this cycle's last beat queues one,
         // so a commit that runs ahead of its request is caught
         if (commit_tvalid)
         begin
            if (exp_cpl_q.size() == 0)
            begin
               $display("Error at %0t ns: commit_tvalid was high with no commit owed",
                        $time);
               stop_with_failure();
            end
            if (commit_tready)
            begin
               c        = exp_cpl_q.pop_front();
               u        = exp_cuser_q.pop_front();
               exp_data = '0;
               exp_data[tx_commit_pkg::CPL_W-1:0] = c;
               exp_keep = '0;
               exp_keep[tx_commit_pkg::CPL_W/8-1:0] = '1;
               check_eq(commit_tdata, exp_data, "commit_tdata");
               check_eq(256'(commit_tkeep), 256'(exp_keep), "commit_tkeep");
               check_eq(256'(commit_tlast), 256'(1), "commit_tlast");
               check_eq(256'(commit_tuser), 256'(u), "commit_tuser");
               commit_count = commit_count + 1;
            end
         end

         sink_xfer = sink_tvalid && sink_tready;
         src_xfer  = src_tvalid && src_tready;
         check_eq(256'(src_xfer), 256'(sink_xfer), "source and sink handshakes");
         if (sink_xfer)
         begin
            if (fwd_data_q.size() == 0)
            begin
               $display("Error at %0t ns: a sink beat was taken that was never driven", $time);
               stop_with_failure();
            end
            check_eq(src_tdata, fwd_data_q.pop_front(), "src_tdata");
            check_eq(256'(src_tkeep), 256'(fwd_keep_q.pop_front()), "src_tkeep");
            check_eq(256'(src_tlast), 256'(fwd_last_q.pop_front()), "src_tlast");
            check_eq(256'(src_tuser), 256'(fwd_user_q.pop_front()), "src_tuser");
            if (sink_tlast)
            begin
               has = pend_has_q.pop_front();
               c   = pend_cpl_q.pop_front();
               u   = pend_user_q.pop_front();
               if (has)
               begin
                  exp_cpl_q.push_back(c);
                  exp_cuser_q.push_back(u);
                  // Latency is fixed only when the output register can take it
                  commit_due = !commit_tvalid || commit_tready;
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial
   begin : stimulus
      int                kind;
      int                nbeats;
      int                gap;
      logic [127:0]      hdr;
      logic [7:0]        first_user;
      logic              suppress;
      logic              needs;
      logic              accepted;
      logic [DATA_W-1:0] beat;
      logic [DATA_W-1:0] fwd;
      rst_n         = 1'b0;
      sink_tvalid   = 1'b0;
      sink_tdata    = '0;
      sink_tkeep    = '0;
      sink_tlast    = 1'b0;
      sink_tuser    = '0;
      src_tready    = 1'b0;
      commit_tready = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int p = 0; p < NUM_PKTS; p++)
      begin
         sink_tvalid = 1'b0;
         gap = {$random(seed)} % 4;
         repeat (gap) tick(accepted);

         kind   = {$random(seed)} % (K_PU_INTR + 1);
         nbeats = 1 + {$random(seed)} % MAX_BEATS;
         beat   = rand_word();
         hdr    = beat[127:0];
         case (kind)
            K_DM_WR, K_PU_WR:
               hdr[63:56] = beat[200] ? tx_commit_pkg::FMT_MWR64 : tx_commit_pkg::FMT_MWR32;
            K_DM_RD, K_PU_RD:
               hdr[63:56] = beat[200] ? tx_commit_pkg::FMT_MRD64 : tx_commit_pkg::FMT_MRD32;
            default:
               hdr[63:56] = tx_commit_pkg::FMT_INTR;
         endcase

         // Bit 0 selects DM and bit 1 asks for no commit about a quarter of the time
         first_user = 8'($random(seed));
         first_user[tx_commit_pkg::USER_DM_BIT] = (kind == K_DM_WR) || (kind == K_DM_RD) ||
                                                  (kind == K_DM_INTR);
         suppress = ({$random(seed)} % 4) == 0;
         first_user[NO_COMMIT] = suppress;
         needs = ((kind == K_DM_WR) || (kind == K_PU_WR) || (kind == K_DM_INTR)) && !suppress;

         pend_has_q.push_back(needs);
         pend_cpl_q.push_back(predict_completion(hdr, kind));
         pend_user_q.push_back(first_user);

         for (int b = 0; b < nbeats; b++)
         begin
            beat = rand_word();
            if (b == 0)
               beat[127:0] = hdr;
            sink_tdata  = beat;
            sink_tkeep  = KEEP_W'($random(seed));
            sink_tlast  = (b == nbeats - 1);
            sink_tuser  = (b == 0) ? first_user : 8'($random(seed));
            sink_tvalid = 1'b1;

            // PU metadata in bytes 8-15 is cleared once a commit carries it
            fwd = beat;
            if ((b == 0) && (kind == K_PU_WR) && needs)
               fwd[127:64] = '0;
            fwd_data_q.push_back(fwd);
            fwd_keep_q.push_back(sink_tkeep);
            fwd_last_q.push_back(sink_tlast);
            fwd_user_q.push_back(sink_tuser);

            do
               tick(accepted);
            while (!accepted);
         end
      end

      // Let the commit stream drain, then watch for strays
      sink_tvalid = 1'b0;
      while (pend_has_q.size() != 0 || exp_cpl_q.size() != 0)
         tick(accepted);
      repeat (20) tick(accepted);

      $display("Sent %0d packets, received %0d commits", NUM_PKTS, commit_count);
      if (fwd_data_q.size() != 0 || exp_cpl_q.size() != 0 || pend_has_q.size() != 0)
      begin
         $display("Error: expected beats or commits were still outstanding at the end");
         stop_with_failure();
      end
      else
      begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

//--- tx_commit_top.f
rtl/tx_commit_pkg.sv
rtl/tx_hdr_decode.sv
rtl/cpl_hdr_build.sv
rtl/commit_ctrl.sv
rtl/commit_skid.sv
rtl/tx_commit_top.sv
tests/tx_commit_tb.sv
